/* hw/pinmux_pkg.sv */
package pinmux_pkg;

  localparam int MAX_PINS           = 32;  // one pad per data bit
  localparam int RESET_STRETCH_BITS = 6;   // top bit sets after 32 cycles

  typedef logic [MAX_PINS-1:0] pin_vec_t;

  typedef enum logic [1:0] {
    FUNC_GPIO = 2'd0,
    FUNC_ALT1 = 2'd1,
    FUNC_ALT2 = 2'd2,
    FUNC_ALT3 = 2'd3
  } pin_func_e;

  typedef pin_func_e [MAX_PINS-1:0] msel_vec_t;  // entry n selects pad n

  typedef struct packed {
    pin_vec_t  gpio_out;
    pin_vec_t  gpio_dir;
    msel_vec_t msel;
  } pad_cfg_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } axil_resp_e;

  typedef struct packed {
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic        bready;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    axil_resp_e  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    axil_resp_e  rresp;
  } axil_rsp_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE_RESP,
    ST_READ_RESP
  } ctrl_state_e;

  localparam logic [7:0] REG_GPIO_OUT = 8'h00;
  localparam logic [7:0] REG_GPIO_DIR = 8'h04;
  localparam logic [7:0] REG_MSEL_LO  = 8'h08;  // pads 0 to 15
  localparam logic [7:0] REG_MSEL_HI  = 8'h0C;  // pads 16 to 31
  localparam logic [7:0] REG_GPIO_IN  = 8'h10;  // read only
  localparam logic [7:0] REG_IRQ      = 8'h14;  // bit 0 irq_out, bit 1 irq in

  // one bit set for every pad that exists in the bank
  function automatic pin_vec_t pin_mask(input int unsigned n);
    pin_vec_t m;
    for (int i = 0; i < MAX_PINS; i++)
    begin
      m[i] = (i < n);
    end
    return m;
  endfunction

  // both select bits set for every pad that exists
  function automatic logic [2*MAX_PINS-1:0] msel_mask(input int unsigned n);
    logic [2*MAX_PINS-1:0] m;
    for (int i = 0; i < MAX_PINS; i++)
    begin
      m[2*i +: 2] = (i < n) ? 2'b11 : 2'b00;
    end
    return m;
  endfunction

endpackage

/* hw/reset_stretch.sv */
`timescale 1ns/1ps

module reset_stretch
(
  input  logic wMEM_CLK,
  input  logic rst_n_i,
  output logic sys_rst_n_o
);

  localparam int TOP = pinmux_pkg::RESET_STRETCH_BITS - 1;

  logic [TOP:0] cnt_q;  // stretch counter

  always_ff @(posedge wMEM_CLK)
  begin
    if (!rst_n_i)
    begin
      cnt_q <= '0;
    end
    else if (!cnt_q[TOP])
    begin
      cnt_q <= cnt_q + 1'b1;  // stops once the top bit is set
    end
  end

  // internal reset releases with the top bit, 32 edges after rst_n_i
  assign sys_rst_n_o = cnt_q[TOP];

endmodule

/* hw/pad_input_sync.sv */
`timescale 1ns/1ps

module pad_input_sync #(
  parameter int NUM_PINS = 31
)
(
  input  logic                 wMEM_CLK,
  input  logic                 rst_n_i,
  input  pinmux_pkg::pin_vec_t pad_in_i,
  input  logic                 irq_i,
  output pinmux_pkg::pin_vec_t pad_in_sync_o,
  output logic                 irq_sync_o
);

  localparam pinmux_pkg::pin_vec_t PIN_MASK = pinmux_pkg::pin_mask(NUM_PINS);

  pinmux_pkg::pin_vec_t pad_meta_q;  // first stage, may go metastable
  pinmux_pkg::pin_vec_t pad_sync_q;
  logic                 irq_meta_q;
  logic                 irq_sync_q;

  always_ff @(posedge wMEM_CLK)
  begin
    if (!rst_n_i)
    begin
      pad_meta_q <= '0;
      pad_sync_q <= '0;
      irq_meta_q <= 1'b0;
      irq_sync_q <= 1'b0;
    end
    else
    begin
      pad_meta_q <= pad_in_i & PIN_MASK;  // unused pads read as zero
      pad_sync_q <= pad_meta_q;
      irq_meta_q <= irq_i;
      irq_sync_q <= irq_meta_q;
    end
  end

  assign pad_in_sync_o = pad_sync_q;
  assign irq_sync_o    = irq_sync_q;

endmodule

/* hw/pinmux_regs.sv */
`timescale 1ns/1ps

module pinmux_regs #(
  parameter int NUM_PINS = 31
)
(
  input  logic                  wMEM_CLK,
  input  logic                  rst_n_i,
  input  pinmux_pkg::axil_req_t axil_req_i,
  output pinmux_pkg::axil_rsp_t axil_rsp_o,
  input  pinmux_pkg::pin_vec_t  pad_in_sync_i,
  input  logic                  irq_sync_i,
  output pinmux_pkg::pad_cfg_t  pad_cfg_o,
  output logic                  irq_o
);

  localparam pinmux_pkg::pin_vec_t PIN_MASK  = pinmux_pkg::pin_mask(NUM_PINS);
  localparam logic [63:0]          MSEL_MASK = pinmux_pkg::msel_mask(NUM_PINS);

  pinmux_pkg::ctrl_state_e state_q;
  pinmux_pkg::pin_vec_t    gpio_out_q;
  pinmux_pkg::pin_vec_t    gpio_dir_q;
  logic [63:0]             msel_q;     // two bits per pad
  logic                    irq_out_q;

  logic [31:0]             rdata_q;    // response payload
  pinmux_pkg::axil_resp_e  bresp_q;
  pinmux_pkg::axil_resp_e  rresp_q;

  logic                    wr_accept;
  logic                    rd_accept;
  logic                    wr_known;
  logic                    rd_known;
  logic [31:0]             rd_word;

  // write wins, a half-presented write still blocks the read
  assign wr_accept = (state_q == pinmux_pkg::ST_IDLE) &&
                     axil_req_i.awvalid && axil_req_i.wvalid;
  assign rd_accept = (state_q == pinmux_pkg::ST_IDLE) && axil_req_i.arvalid &&
                     !axil_req_i.awvalid && !axil_req_i.wvalid;

  always_comb
  begin
    case (axil_req_i.awaddr)
      pinmux_pkg::REG_GPIO_OUT,
      pinmux_pkg::REG_GPIO_DIR,
      pinmux_pkg::REG_MSEL_LO,
      pinmux_pkg::REG_MSEL_HI,
      pinmux_pkg::REG_GPIO_IN,  // accepted, write ignored
      pinmux_pkg::REG_IRQ:      wr_known = 1'b1;
      default:                  wr_known = 1'b0;
    endcase
  end

  always_comb
  begin
    rd_known = 1'b1;
    case (axil_req_i.araddr)
      pinmux_pkg::REG_GPIO_OUT: rd_word = gpio_out_q;
      pinmux_pkg::REG_GPIO_DIR: rd_word = gpio_dir_q;
      pinmux_pkg::REG_MSEL_LO:  rd_word = msel_q[31:0];
      pinmux_pkg::REG_MSEL_HI:  rd_word = msel_q[63:32];
      pinmux_pkg::REG_GPIO_IN:  rd_word = pad_in_sync_i;
      pinmux_pkg::REG_IRQ:      rd_word = {30'd0, irq_sync_i, irq_out_q};
      default:
      begin
        rd_word  = '0;  // unknown offset reads zero
        rd_known = 1'b0;
      end
    endcase
  end

  always_ff @(posedge wMEM_CLK)
  begin
    if (!rst_n_i)
    begin
      state_q    <= pinmux_pkg::ST_IDLE;
      gpio_out_q <= '0;
      gpio_dir_q <= '0;  // all pads released
      msel_q     <= '0;
      irq_out_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        pinmux_pkg::ST_IDLE:
        begin
          if (wr_accept)
          begin
            state_q <= pinmux_pkg::ST_WRITE_RESP;
          end
          else if (rd_accept)
          begin
            state_q <= pinmux_pkg::ST_READ_RESP;
          end
        end
        pinmux_pkg::ST_WRITE_RESP:
        begin
          if (axil_req_i.bready)
          begin
            state_q <= pinmux_pkg::ST_IDLE;
          end
        end
        pinmux_pkg::ST_READ_RESP:
        begin
          if (axil_req_i.rready)
          begin
            state_q <= pinmux_pkg::ST_IDLE;
          end
        end
        default: state_q <= pinmux_pkg::ST_IDLE;
      endcase

      if (wr_accept)
      begin
        case (axil_req_i.awaddr)
          pinmux_pkg::REG_GPIO_OUT: gpio_out_q <= axil_req_i.wdata & PIN_MASK;
          pinmux_pkg::REG_GPIO_DIR: gpio_dir_q <= axil_req_i.wdata & PIN_MASK;
          pinmux_pkg::REG_MSEL_LO:  msel_q[31:0]  <= axil_req_i.wdata & MSEL_MASK[31:0];
          pinmux_pkg::REG_MSEL_HI:  msel_q[63:32] <= axil_req_i.wdata & MSEL_MASK[63:32];
          pinmux_pkg::REG_IRQ:      irq_out_q <= axil_req_i.wdata[0];
          default: ;
        endcase
      end
    end
  end

  // response payload, held while the response is pending
  always_ff @(posedge wMEM_CLK)
  begin
    if (wr_accept)
    begin
      bresp_q <= wr_known ? pinmux_pkg::RESP_OKAY : pinmux_pkg::RESP_SLVERR;
    end
    if (rd_accept)
    begin
      rdata_q <= rd_word;
      rresp_q <= rd_known ? pinmux_pkg::RESP_OKAY : pinmux_pkg::RESP_SLVERR;
    end
  end

  assign axil_rsp_o.awready = wr_accept;
  assign axil_rsp_o.wready  = wr_accept;
  assign axil_rsp_o.bvalid  = (state_q == pinmux_pkg::ST_WRITE_RESP);
  assign axil_rsp_o.bresp   = bresp_q;
  assign axil_rsp_o.arready = rd_accept;
  assign axil_rsp_o.rvalid  = (state_q == pinmux_pkg::ST_READ_RESP);
  assign axil_rsp_o.rdata   = rdata_q;
  assign axil_rsp_o.rresp   = rresp_q;

  assign pad_cfg_o.gpio_out = gpio_out_q;
  assign pad_cfg_o.gpio_dir = gpio_dir_q;
  assign pad_cfg_o.msel     = pinmux_pkg::msel_vec_t'(msel_q);
  assign irq_o              = irq_out_q;

endmodule

/* hw/pad_mux.sv */
`timescale 1ns/1ps

module pad_mux #(
  parameter int NUM_PINS = 31
)
(
  input  pinmux_pkg::pad_cfg_t pad_cfg_i,
  input  pinmux_pkg::pin_vec_t alt1_out_i,
  input  pinmux_pkg::pin_vec_t alt2_out_i,
  input  pinmux_pkg::pin_vec_t alt2_oe_i,
  input  pinmux_pkg::pin_vec_t alt3_out_i,
  input  pinmux_pkg::pin_vec_t alt3_oe_i,
  output pinmux_pkg::pin_vec_t pad_out_o,
  output pinmux_pkg::pin_vec_t pad_oe_o
);

  for (genvar i = 0; i < NUM_PINS; i++) begin : g_pad
    logic out_sel;
    logic oe_sel;

    always_comb
    begin
      case (pad_cfg_i.msel[i])
        pinmux_pkg::FUNC_GPIO:
        begin
          out_sel = pad_cfg_i.gpio_out[i];
          oe_sel  = pad_cfg_i.gpio_dir[i];  // driven only as output
        end
        pinmux_pkg::FUNC_ALT1:
        begin
          out_sel = alt1_out_i[i];
          oe_sel  = 1'b1;                   // always driven
        end
        pinmux_pkg::FUNC_ALT2:
        begin
          out_sel = alt2_out_i[i];
          oe_sel  = alt2_oe_i[i];
        end
        default:
        begin
          out_sel = alt3_out_i[i];
          oe_sel  = alt3_oe_i[i];
        end
      endcase
    end

    assign pad_out_o[i] = out_sel & oe_sel;  // released pad reads low
    assign pad_oe_o[i]  = oe_sel;
  end

  // pads beyond the bank stay quiet
  for (genvar j = NUM_PINS; j < pinmux_pkg::MAX_PINS; j++) begin : g_unused
    assign pad_out_o[j] = 1'b0;
    assign pad_oe_o[j]  = 1'b0;
  end

endmodule

/* hw/pinmux_top.sv */
`timescale 1ns/1ps

module pinmux_top #(
  parameter int NUM_PINS = 31  // board header bank
)
(
  input  logic                  wMEM_CLK,
  input  logic                  rst_n_i,
  input  pinmux_pkg::axil_req_t axil_req_i,
  output pinmux_pkg::axil_rsp_t axil_rsp_o,
  input  pinmux_pkg::pin_vec_t  pad_in_i,
  input  pinmux_pkg::pin_vec_t  alt1_out_i,
  input  pinmux_pkg::pin_vec_t  alt2_out_i,
  input  pinmux_pkg::pin_vec_t  alt2_oe_i,
  input  pinmux_pkg::pin_vec_t  alt3_out_i,
  input  pinmux_pkg::pin_vec_t  alt3_oe_i,
  input  logic                  irq_i,
  output pinmux_pkg::pin_vec_t  pad_out_o,
  output pinmux_pkg::pin_vec_t  pad_oe_o,
  output logic                  irq_o
);

  logic                 sys_rst_n;    // stretched reset
  pinmux_pkg::pin_vec_t pad_in_sync;
  logic                 irq_sync;
  pinmux_pkg::pad_cfg_t pad_cfg;

  reset_stretch u_reset_stretch (
    .wMEM_CLK    (wMEM_CLK),
    .rst_n_i     (rst_n_i),
    .sys_rst_n_o (sys_rst_n)
  );

  pad_input_sync #(.NUM_PINS(NUM_PINS)) u_pad_input_sync (
    .wMEM_CLK      (wMEM_CLK),
    .rst_n_i       (sys_rst_n),
    .pad_in_i      (pad_in_i),
    .irq_i         (irq_i),
    .pad_in_sync_o (pad_in_sync),
    .irq_sync_o    (irq_sync)
  );

  pinmux_regs #(.NUM_PINS(NUM_PINS)) u_pinmux_regs (
    .wMEM_CLK      (wMEM_CLK),
    .rst_n_i       (sys_rst_n),
    .axil_req_i    (axil_req_i),
    .axil_rsp_o    (axil_rsp_o),
    .pad_in_sync_i (pad_in_sync),
    .irq_sync_i    (irq_sync),
    .pad_cfg_o     (pad_cfg),
    .irq_o         (irq_o)
  );

  pad_mux #(.NUM_PINS(NUM_PINS)) u_pad_mux (
    .pad_cfg_i  (pad_cfg),
    .alt1_out_i (alt1_out_i),
    .alt2_out_i (alt2_out_i),
    .alt2_oe_i  (alt2_oe_i),
    .alt3_out_i (alt3_out_i),
    .alt3_oe_i  (alt3_oe_i),
    .pad_out_o  (pad_out_o),
    .pad_oe_o   (pad_oe_o)
  );

endmodule

/* verification/tb_pinmux_tasks.svh */
`ifndef TB_PINMUX_TASKS_SVH
`define TB_PINMUX_TASKS_SVH

  // galois form, one step per random bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    abort_run();
  endtask

  task automatic check_vec(input string name, input pinmux_pkg::pin_vec_t exp,
                           input pinmux_pkg::pin_vec_t act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input pinmux_pkg::axil_resp_e exp,
                            input pinmux_pkg::axil_resp_e act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected %s (%b), actual %s (%b)", name, exp.name(), exp,
               act.name(), act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // address and data together, bready kept low until finish
  task automatic axil_write_start(input logic [7:0] addr, input logic [31:0] data);
    int n;
    @(negedge wMEM_CLK);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.bready  = 1'b0;
    n = 0;
    @(negedge wMEM_CLK);
    while (axil_rsp.bvalid !== 1'b1)
    begin
      if (n >= TIMEOUT_CYCLES)
        report_timeout("bvalid of a write");
      else
      begin
        n++;
        @(negedge wMEM_CLK);
      end
    end
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
  endtask

  task automatic axil_write_finish(output pinmux_pkg::axil_resp_e resp);
    int n;
    resp = axil_rsp.bresp;  // held while bvalid is up
    axil_req.bready = 1'b1;
    n = 0;
    @(negedge wMEM_CLK);
    while (axil_rsp.bvalid !== 1'b0)
    begin
      if (n >= TIMEOUT_CYCLES)
        report_timeout("bvalid to drop after bready");
      else
      begin
        n++;
        @(negedge wMEM_CLK);
      end
    end
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output pinmux_pkg::axil_resp_e resp);
    axil_write_start(addr, data);
    axil_write_finish(resp);
  endtask

  task automatic axil_read_start(input logic [7:0] addr);
    @(negedge wMEM_CLK);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b0;
  endtask

  task automatic axil_read_finish(output logic [31:0] data,
                                  output pinmux_pkg::axil_resp_e resp);
    int n;
    n = 0;
    @(negedge wMEM_CLK);
    while (axil_rsp.rvalid !== 1'b1)
    begin
      if (n >= TIMEOUT_CYCLES)
        report_timeout("rvalid of a read");
      else
      begin
        n++;
        @(negedge wMEM_CLK);
      end
    end
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    n = 0;
    @(negedge wMEM_CLK);
    while (axil_rsp.rvalid !== 1'b0)
    begin
      if (n >= TIMEOUT_CYCLES)
        report_timeout("rvalid to drop after rready");
      else
      begin
        n++;
        @(negedge wMEM_CLK);
      end
    end
    axil_req.rready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output pinmux_pkg::axil_resp_e resp);
    axil_read_start(addr);
    axil_read_finish(data, resp);
  endtask

  task automatic write_okay(input string name, input logic [7:0] addr,
                            input logic [31:0] data);
    pinmux_pkg::axil_resp_e resp;
    axil_write(addr, data, resp);
    check_resp({name, " bresp"}, pinmux_pkg::RESP_OKAY, resp);
  endtask

  task automatic read_expect(input string name, input logic [7:0] addr,
                             input pinmux_pkg::pin_vec_t exp);
    logic [31:0]            data;
    pinmux_pkg::axil_resp_e resp;
    axil_read(addr, data, resp);
    check_resp({name, " rresp"}, pinmux_pkg::RESP_OKAY, resp);
    check_vec(name, exp, data);
  endtask

  // pad rule table, a released pad reads low
  task automatic expected_pads(input stim_t s, input logic [63:0] sel,
                               output pinmux_pkg::pin_vec_t out,
                               output pinmux_pkg::pin_vec_t oe);
    pinmux_pkg::pin_func_e f;
    logic                  src;
    logic                  en;
    out = '0;
    oe  = '0;
    for (int p = 0; p < NUM_PINS; p++)
    begin
      f = pinmux_pkg::pin_func_e'(sel[2*p +: 2]);
      case (f)
        pinmux_pkg::FUNC_GPIO:
        begin
          src = s.gpio_out[p];
          en  = s.gpio_dir[p];
        end
        pinmux_pkg::FUNC_ALT1:
        begin
          src = s.alt1_out[p];
          en  = 1'b1;
        end
        pinmux_pkg::FUNC_ALT2:
        begin
          src = s.alt2_out[p];
          en  = s.alt2_oe[p];
        end
        default:
        begin
          src = s.alt3_out[p];
          en  = s.alt3_oe[p];
        end
      endcase
      oe[p]  = en;
      out[p] = en ? src : 1'b0;
    end
  endtask

  task automatic check_idle(input string name);
    check_bit({name, " awready"}, 1'b0, axil_rsp.awready);
    check_bit({name, " wready"}, 1'b0, axil_rsp.wready);
    check_bit({name, " arready"}, 1'b0, axil_rsp.arready);
    check_bit({name, " bvalid"}, 1'b0, axil_rsp.bvalid);
    check_bit({name, " rvalid"}, 1'b0, axil_rsp.rvalid);
    check_vec({name, " pad_oe_o"}, '0, pad_oe_o);
    check_bit({name, " irq_o"}, 1'b0, irq_o);
  endtask

`endif

/* verification/tb_pinmux_top.sv */
`timescale 1ns/1ps

module tb_pinmux_top;

  localparam int          NUM_PINS       = 31;
  localparam int          TIMEOUT_CYCLES = 40;  // per wait loop
  localparam int          NUM_ENTRIES    = 7;
  localparam logic [31:0] LFSR_SEED      = 32'h31537033;
  localparam logic [7:0]  BAD_OFFSET     = 8'h18;
  localparam pinmux_pkg::pin_vec_t PIN_MASK =
    pinmux_pkg::pin_vec_t'((64'd1 << NUM_PINS) - 64'd1);

  typedef struct packed {
    logic                  lfsr_fill;  // random selects and alt buses
    pinmux_pkg::pin_func_e func;       // same select on every pad
    pinmux_pkg::pin_vec_t  gpio_out;
    pinmux_pkg::pin_vec_t  gpio_dir;
    pinmux_pkg::pin_vec_t  alt1_out;
    pinmux_pkg::pin_vec_t  alt2_out;
    pinmux_pkg::pin_vec_t  alt2_oe;
    pinmux_pkg::pin_vec_t  alt3_out;
    pinmux_pkg::pin_vec_t  alt3_oe;
  } stim_t;

  logic                   wMEM_CLK;
  logic                   rst_n_i;
  pinmux_pkg::axil_req_t  axil_req;
  pinmux_pkg::axil_rsp_t  axil_rsp;
  pinmux_pkg::pin_vec_t   pad_in_i;
  pinmux_pkg::pin_vec_t   alt1_out_i;
  pinmux_pkg::pin_vec_t   alt2_out_i;
  pinmux_pkg::pin_vec_t   alt2_oe_i;
  pinmux_pkg::pin_vec_t   alt3_out_i;
  pinmux_pkg::pin_vec_t   alt3_oe_i;
  logic                   irq_i;
  pinmux_pkg::pin_vec_t   pad_out_o;
  pinmux_pkg::pin_vec_t   pad_oe_o;
  logic                   irq_o;

  logic [31:0]            lfsr_state;
  stim_t                  cur;
  logic [63:0]            sel_word;
  logic [63:0]            sel_exp;    // pads past the bank masked off
  logic [31:0]            rnd;
  logic [31:0]            rdata;
  pinmux_pkg::axil_resp_e resp;
  pinmux_pkg::pin_vec_t   exp_out;
  pinmux_pkg::pin_vec_t   exp_oe;
  pinmux_pkg::pin_vec_t   held_out;
  pinmux_pkg::pin_vec_t   held_oe;

  stim_t stim_tbl [NUM_ENTRIES] = '{
    '{1'b0, pinmux_pkg::FUNC_GPIO, 32'hA5A5_5A5A, 32'hFFFF_FFFF,
      32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
    '{1'b0, pinmux_pkg::FUNC_GPIO, 32'hFFFF_FFFF, 32'h0F0F_00FF,
      32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF},
    '{1'b0, pinmux_pkg::FUNC_ALT1, 32'h0, 32'h0,
      32'h5555_AAAA, 32'hFFFF_FFFF, 32'h0, 32'h0, 32'hFFFF_FFFF},
    '{1'b0, pinmux_pkg::FUNC_ALT2, 32'hFFFF_0000, 32'hFFFF_FFFF,
      32'hFFFF_FFFF, 32'hC3C3_C3C3, 32'h00FF_FF00, 32'h0, 32'h0},
    '{1'b0, pinmux_pkg::FUNC_ALT3, 32'h0, 32'h0,
      32'h0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h9696_F0F0, 32'hFFFF_0FF0},
    '{1'b1, pinmux_pkg::FUNC_GPIO, 32'h3C3C_3C3C, 32'h5A5A_A5A5,
      32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
    '{1'b1, pinmux_pkg::FUNC_GPIO, 32'h8181_8181, 32'hFFFF_0000,
      32'h0, 32'h0, 32'h0, 32'h0, 32'h0}
  };

  task automatic abort_run();
    $display("test failed");
    $fatal(1);
  endtask

  `include "tb_pinmux_tasks.svh"

  pinmux_top #(.NUM_PINS(NUM_PINS)) UUT (
    .wMEM_CLK   (wMEM_CLK),
    .rst_n_i    (rst_n_i),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp),
    .pad_in_i   (pad_in_i),
    .alt1_out_i (alt1_out_i),
    .alt2_out_i (alt2_out_i),
    .alt2_oe_i  (alt2_oe_i),
    .alt3_out_i (alt3_out_i),
    .alt3_oe_i  (alt3_oe_i),
    .irq_i      (irq_i),
    .pad_out_o  (pad_out_o),
    .pad_oe_o   (pad_oe_o),
    .irq_o      (irq_o)
  );

  initial
  begin
    wMEM_CLK = 1'b0;
    forever #20 wMEM_CLK = ~wMEM_CLK;  // 40 ns period
  end

  initial
  begin
    rst_n_i    = 1'b0;
    axil_req   = '0;
    pad_in_i   = '0;
    alt1_out_i = '0;
    alt2_out_i = '0;
    alt2_oe_i  = '0;
    alt3_out_i = '0;
    alt3_oe_i  = '0;
    irq_i      = 1'b0;
    lfsr_state = LFSR_SEED;
    repeat (2) @(negedge wMEM_CLK);
    rst_n_i = 1'b1;

    // 32 edges of stretch, then a little margin
    for (int c = 0; c < 34; c++)
    begin
      @(negedge wMEM_CLK);
      check_idle("reset stretch");
    end
    read_expect("reset gpio_out", pinmux_pkg::REG_GPIO_OUT, '0);
    read_expect("reset gpio_dir", pinmux_pkg::REG_GPIO_DIR, '0);
    read_expect("reset msel_lo", pinmux_pkg::REG_MSEL_LO, '0);
    read_expect("reset msel_hi", pinmux_pkg::REG_MSEL_HI, '0);
    axil_read(pinmux_pkg::REG_IRQ, rdata, resp);
    check_resp("reset irq rresp", pinmux_pkg::RESP_OKAY, resp);
    check_bit("reset irq_out bit", 1'b0, rdata[0]);
    check_idle("after reset");

    for (int e = 0; e < NUM_ENTRIES; e++)
    begin
      cur = stim_tbl[e];
      for (int p = 0; p < pinmux_pkg::MAX_PINS; p++)
      begin
        if (cur.lfsr_fill)
          take_bits(2, rnd);
        else
          rnd = 32'(cur.func);
        sel_word[2*p +: 2] = rnd[1:0];
        sel_exp[2*p +: 2]  = (p < NUM_PINS) ? rnd[1:0] : 2'b00;
      end
      if (cur.lfsr_fill)
      begin
        take_bits(32, cur.alt1_out);
        take_bits(32, cur.alt2_out);
        take_bits(32, cur.alt2_oe);
        take_bits(32, cur.alt3_out);
        take_bits(32, cur.alt3_oe);
      end
      @(negedge wMEM_CLK);
      alt1_out_i = cur.alt1_out;
      alt2_out_i = cur.alt2_out;
      alt2_oe_i  = cur.alt2_oe;
      alt3_out_i = cur.alt3_out;
      alt3_oe_i  = cur.alt3_oe;
      write_okay($sformatf("entry %0d dir", e), pinmux_pkg::REG_GPIO_DIR, cur.gpio_dir);
      write_okay($sformatf("entry %0d out", e), pinmux_pkg::REG_GPIO_OUT, cur.gpio_out);
      write_okay($sformatf("entry %0d msel_lo", e), pinmux_pkg::REG_MSEL_LO, sel_word[31:0]);
      write_okay($sformatf("entry %0d msel_hi", e), pinmux_pkg::REG_MSEL_HI, sel_word[63:32]);
      expected_pads(cur, sel_exp, exp_out, exp_oe);
      check_vec($sformatf("entry %0d pad_oe_o", e), exp_oe, pad_oe_o);
      check_vec($sformatf("entry %0d pad_out_o", e), exp_out, pad_out_o);
      read_expect($sformatf("entry %0d gpio_out rd", e), pinmux_pkg::REG_GPIO_OUT,
                  cur.gpio_out & PIN_MASK);
      read_expect($sformatf("entry %0d gpio_dir rd", e), pinmux_pkg::REG_GPIO_DIR,
                  cur.gpio_dir & PIN_MASK);
      read_expect($sformatf("entry %0d msel_lo rd", e), pinmux_pkg::REG_MSEL_LO, sel_exp[31:0]);
      read_expect($sformatf("entry %0d msel_hi rd", e), pinmux_pkg::REG_MSEL_HI, sel_exp[63:32]);
    end

    take_bits(32, rnd);
    @(negedge wMEM_CLK);
    pad_in_i = rnd;
    irq_i    = 1'b1;
    repeat (3) @(negedge wMEM_CLK);  // past the two sync stages
    read_expect("gpio_in", pinmux_pkg::REG_GPIO_IN, rnd & PIN_MASK);
    axil_read(pinmux_pkg::REG_IRQ, rdata, resp);
    check_bit("irq input high", 1'b1, rdata[1]);
    irq_i = 1'b0;
    repeat (3) @(negedge wMEM_CLK);
    axil_read(pinmux_pkg::REG_IRQ, rdata, resp);
    check_bit("irq input low", 1'b0, rdata[1]);
    write_okay("irq set", pinmux_pkg::REG_IRQ, 32'h1);
    check_bit("irq_o set", 1'b1, irq_o);
    write_okay("irq clear", pinmux_pkg::REG_IRQ, 32'h0);
    check_bit("irq_o clear", 1'b0, irq_o);

    held_out = pad_out_o;
    held_oe  = pad_oe_o;
    axil_write(BAD_OFFSET, 32'hFFFF_FFFF, resp);
    check_resp("bad offset bresp", pinmux_pkg::RESP_SLVERR, resp);
    axil_read(BAD_OFFSET, rdata, resp);
    check_resp("bad offset rresp", pinmux_pkg::RESP_SLVERR, resp);
    check_vec("bad offset rdata", '0, rdata);
    check_vec("bad offset pad_out_o", held_out, pad_out_o);
    check_vec("bad offset pad_oe_o", held_oe, pad_oe_o);

    // write response stalled, read queued behind it
    axil_write_start(pinmux_pkg::REG_GPIO_OUT, 32'hDEAD_BEEF);
    repeat (4)
    begin
      @(negedge wMEM_CLK);
      check_bit("stalled bvalid", 1'b1, axil_rsp.bvalid);
    end
    axil_read_start(pinmux_pkg::REG_GPIO_OUT);
    repeat (3)
    begin
      @(negedge wMEM_CLK);
      check_bit("blocked arready", 1'b0, axil_rsp.arready);
      check_bit("blocked rvalid", 1'b0, axil_rsp.rvalid);
      check_bit("stalled bvalid", 1'b1, axil_rsp.bvalid);
    end
    axil_write_finish(resp);
    check_resp("stalled write bresp", pinmux_pkg::RESP_OKAY, resp);
    axil_read_finish(rdata, resp);
    check_resp("queued read rresp", pinmux_pkg::RESP_OKAY, resp);
    check_vec("queued read data", 32'hDEAD_BEEF & PIN_MASK, rdata);

    $display("test passed");
    $finish;
  end

endmodule

/* sim.f */
+incdir+verification
hw/pinmux_pkg.sv
hw/reset_stretch.sv
hw/pad_input_sync.sv
hw/pinmux_regs.sv
hw/pad_mux.sv
hw/pinmux_top.sv
verification/tb_pinmux_top.sv
